// ==== config_pkg.sv ====
package config_pkg;

   // field widths of one configuration write
   localparam int ID_BITS      = 8;
   localparam int PAYLOAD_BITS = 16;

   // a frame carries the address first and then the payload, each MSB first
   localparam int FRAME_BITS = ID_BITS + PAYLOAD_BITS;

   typedef logic [ID_BITS-1:0]      node_id_t;   // node address on the bus
   typedef logic [PAYLOAD_BITS-1:0] payload_t;   // data part of a write
   typedef logic [FRAME_BITS-1:0]   frame_t;     // address and payload as shifted

   // bit counter inside a frame, holds 0 up to FRAME_BITS-1
   typedef logic [4:0] frame_cnt_t;

   // every node accepts a write sent to this address
   localparam node_id_t BROADCAST_ID = 8'hFF;

   // one-bit serial configuration bus
   // valid is high for every cycle that carries a frame bit
   typedef struct packed {
      logic valid;  // frame bit present
      logic dat;    // serial data
   } config_s;

   // serializer states
   typedef enum logic [1:0] {
      IDLE,   // waiting for a host request
      SHIFT,  // frame bits going out on the bus
      ACK     // frame sent, holding ack until req drops
   } ser_state_e;

endpackage

// ==== node_pkg.sv ====
package node_pkg;

   // number of configuration nodes in the chain
   localparam int NUM_NODES = 3;

   // addresses of the nodes, in chain order
   localparam config_pkg::node_id_t NODE0_ID = 8'h01;
   localparam config_pkg::node_id_t NODE1_ID = 8'h02;
   localparam config_pkg::node_id_t NODE2_ID = 8'h10;

   // width of each node's configurable register
   localparam int NODE0_BITS = 4;
   localparam int NODE1_BITS = 8;
   localparam int NODE2_BITS = 16;

   // register types of the three nodes
   typedef logic [NODE0_BITS-1:0] node0_data_t;
   typedef logic [NODE1_BITS-1:0] node1_data_t;
   typedef logic [NODE2_BITS-1:0] node2_data_t;

   // values the registers take on reset
   localparam node0_data_t NODE0_RST = 4'h5;
   localparam node1_data_t NODE1_RST = 8'hA0;
   localparam node2_data_t NODE2_RST = 16'h1234;

endpackage

// ==== config_serializer.sv ====
`timescale 1ns/100ps

module config_serializer
   import config_pkg::*;
(
   input  logic     clk_dst_i,
   input  logic     rst_n_i,

   input  logic     host_req_i,
   input  node_id_t host_id_i,
   input  payload_t host_payload_i,
   output logic     host_ack_o,

   output config_s  bus_o
);

   ser_state_e state_r, state_n;
   frame_t     shift_r;  // MSB is the bit on the bus
   frame_cnt_t cnt_r;    // bits already sent in this frame
   logic       last_bit;

   assign last_bit = (cnt_r == frame_cnt_t'(FRAME_BITS - 1));

   always_comb begin
      state_n = state_r;
      case (state_r)
         IDLE:    if (host_req_i) state_n = SHIFT;
         SHIFT:   if (last_bit) state_n = ACK;
         ACK:     if (!host_req_i) state_n = IDLE;  // four-phase return to zero
         default: state_n = IDLE;
      endcase
   end

   always_ff @(posedge clk_dst_i) begin
      if (!rst_n_i) begin
         state_r <= IDLE;
         cnt_r   <= '0;
      end else begin
         state_r <= state_n;
         if (state_r == SHIFT)
            cnt_r <= last_bit ? '0 : cnt_r + 1'b1;
      end
   end

   // the write is sampled on the first cycle that req is seen high
   always_ff @(posedge clk_dst_i) begin
      if (state_r == IDLE && host_req_i) begin
         shift_r <= {host_id_i, host_payload_i};
      end else if (state_r == SHIFT) begin
         shift_r <= {shift_r[FRAME_BITS-2:0], 1'b0};
      end
   end

   assign host_ack_o = (state_r == ACK);

   assign bus_o.valid = (state_r == SHIFT);
   assign bus_o.dat   = shift_r[FRAME_BITS-1];

   // a frame is exactly FRAME_BITS valid cycles and the bus goes idle right after it
   a_frame_shape: assert property (
      @(posedge clk_dst_i) disable iff (!rst_n_i)
      $rose(bus_o.valid) |-> bus_o.valid [*FRAME_BITS] ##1 !bus_o.valid
   ) else $error("serializer frame is not %0d valid cycles", FRAME_BITS);

   // the host keeps address and payload steady until it sees ack
   a_host_stable: assert property (
      @(posedge clk_dst_i) disable iff (!rst_n_i)
      (host_req_i && !host_ack_o) |=>
         (!host_req_i || host_ack_o || $stable({host_id_i, host_payload_i}))
   ) else $error("host write changed while req was pending");

endmodule

// ==== config_node.sv ====
`timescale 1ns/100ps

module config_node
   import config_pkg::*;
#(
   parameter node_id_t                 id_p        = '0,
   parameter int                       data_bits_p = 8,
   parameter logic [data_bits_p-1:0]   reset_val_p = '0
) (
   input  logic                   clk_dst_i,
   input  logic                   rst_n_i,

   input  config_s                config_i,
   output config_s                config_o,

   output logic [data_bits_p-1:0] data_o
);

   config_s    relay_r;   // bus copy handed to the next node
   frame_t     rx_r;      // bits of the frame received so far
   frame_t     frame_n;   // frame including the bit on the bus now
   frame_cnt_t cnt_r;
   logic       last_bit;
   logic       hit;
   logic [data_bits_p-1:0] data_r;

   // the relay stage adds one cycle per node along the chain
   always_ff @(posedge clk_dst_i) begin
      if (!rst_n_i) begin
         relay_r <= '0;
      end else begin
         relay_r <= config_i;
      end
   end

   assign config_o = relay_r;

   assign frame_n  = {rx_r[FRAME_BITS-2:0], config_i.dat};
   assign last_bit = config_i.valid && (cnt_r == frame_cnt_t'(FRAME_BITS - 1));

   // address sits in the top bits of a complete frame
   assign hit = (frame_n[FRAME_BITS-1 -: ID_BITS] == id_p) ||
                (frame_n[FRAME_BITS-1 -: ID_BITS] == BROADCAST_ID);

   always_ff @(posedge clk_dst_i) begin
      if (config_i.valid)
         rx_r <= frame_n;
   end

   always_ff @(posedge clk_dst_i) begin
      if (!rst_n_i) begin
         cnt_r <= '0;
      end else if (last_bit) begin
         cnt_r <= '0;  // ready for the next frame
      end else if (config_i.valid) begin
         cnt_r <= cnt_r + 1'b1;
      end
   end

   // the register loads on the same edge that takes in the final bit,
   // so data_o shows the new value in the following cycle
   always_ff @(posedge clk_dst_i) begin
      if (!rst_n_i) begin
         data_r <= reset_val_p;
      end else if (last_bit && hit) begin
         data_r <= frame_n[data_bits_p-1:0];  // low payload bits
      end
   end

   assign data_o = data_r;

   // the bus idles for at least one cycle after every frame
   a_frame_gap: assert property (
      @(posedge clk_dst_i) disable iff (!rst_n_i)
      last_bit |=> !config_i.valid
   ) else $error("node %0h saw no idle cycle after a frame", id_p);

   // once a frame has started, the bus stays valid up to its last bit
   a_frame_unbroken: assert property (
      @(posedge clk_dst_i) disable iff (!rst_n_i)
      (cnt_r != '0) |-> config_i.valid
   ) else $error("node %0h saw a frame cut short", id_p);

endmodule

// ==== config_net_top.sv ====
`timescale 1ns/100ps

module config_net_top
   import config_pkg::*, node_pkg::*;
(
   input  logic        clk_dst_i,
   input  logic        rst_n_i,

   input  logic        host_req_i,
   input  node_id_t    host_id_i,
   input  payload_t    host_payload_i,
   output logic        host_ack_o,

   output node0_data_t node0_data_o,
   output node1_data_t node1_data_o,
   output node2_data_t node2_data_o
);

   config_s bus_0;   // serializer to node 0
   config_s bus_01;  // node 0 relay to node 1
   config_s bus_12;  // node 1 relay to node 2

   config_serializer serializer (
      .clk_dst_i      (clk_dst_i),
      .rst_n_i        (rst_n_i),
      .host_req_i     (host_req_i),
      .host_id_i      (host_id_i),
      .host_payload_i (host_payload_i),
      .host_ack_o     (host_ack_o),
      .bus_o          (bus_0)
   );

   config_node #(
      .id_p        (NODE0_ID),
      .data_bits_p (NODE0_BITS),
      .reset_val_p (NODE0_RST)
   ) node_0 (
      .clk_dst_i (clk_dst_i),
      .rst_n_i   (rst_n_i),
      .config_i  (bus_0),
      .config_o  (bus_01),
      .data_o    (node0_data_o)
   );

   config_node #(
      .id_p        (NODE1_ID),
      .data_bits_p (NODE1_BITS),
      .reset_val_p (NODE1_RST)
   ) node_1 (
      .clk_dst_i (clk_dst_i),
      .rst_n_i   (rst_n_i),
      .config_i  (bus_01),
      .config_o  (bus_12),
      .data_o    (node1_data_o)
   );

   // last node in the chain, its relay output goes nowhere
   config_node #(
      .id_p        (NODE2_ID),
      .data_bits_p (NODE2_BITS),
      .reset_val_p (NODE2_RST)
   ) node_2 (
      .clk_dst_i (clk_dst_i),
      .rst_n_i   (rst_n_i),
      .config_i  (bus_12),
      .config_o  (),
      .data_o    (node2_data_o)
   );

endmodule

// ==== bind_node.sv ====
`timescale 1ns/100ps

module bind_node
   import config_pkg::*;
#(
   parameter node_id_t id_p        = '0,
   parameter int       data_bits_p = 8
) (
   input  logic                   clk_dst_i,
   input  logic                   rst_n_i,
   input  logic [data_bits_p-1:0] data_i,
   input  logic [data_bits_p-1:0] exp_i,   // value the testbench expects right now
   output int                     err_cnt_o,
   output int                     chg_cnt_o
);

   logic [data_bits_p-1:0] prev;
   int err_cnt = 0;
   int chg_cnt = 0;

   // outputs move on rising edges, so the falling edge sees them settled
   always @(negedge clk_dst_i) begin
      if (rst_n_i === 1'b1 && data_i !== prev) begin
         chg_cnt++;
         $display("%0t: node %02h data_o changed %h -> %h", $time, id_p, prev, data_i);
         if (data_i !== exp_i) begin
            err_cnt++;
            $display("** Error: node %02h data_o expected %h got %h", id_p, exp_i, data_i);
         end
      end
      prev = data_i;
   end

   assign err_cnt_o = err_cnt;
   assign chg_cnt_o = chg_cnt;

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen (
   output logic clk_o,
   output logic rst_n_o
);

   initial clk_o = 1'b0;
   always #4 clk_o = ~clk_o;  // 8 ns period

   initial begin
      rst_n_o = 1'b0;
      repeat (2) @(posedge clk_o);
      rst_n_o <= 1'b1;
   end

endmodule

// ==== config_net_tb.sv ====
`timescale 1ns/100ps

module config_net_tb
   import config_pkg::*, node_pkg::*;
();

   localparam int WAIT_LIMIT = 100;

   logic        clk, rst_n;
   logic        host_req;
   node_id_t    host_id;
   payload_t    host_payload;
   logic        host_ack;
   node0_data_t node0_data, exp0;
   node1_data_t node1_data, exp1;
   node2_data_t node2_data, exp2;
   int          mon0_err, mon1_err, mon2_err;
   int          mon0_chg, mon1_chg, mon2_chg;
   int          exp_chg [NUM_NODES];
   int          err_cnt   = 0;
   bit          timed_out = 1'b0;
   int          seed      = 32'hdca2;

   tb_clock_gen clock_gen (.clk_o(clk), .rst_n_o(rst_n));

   config_net_top uut (
      .clk_dst_i      (clk),
      .rst_n_i        (rst_n),
      .host_req_i     (host_req),
      .host_id_i      (host_id),
      .host_payload_i (host_payload),
      .host_ack_o     (host_ack),
      .node0_data_o   (node0_data),
      .node1_data_o   (node1_data),
      .node2_data_o   (node2_data)
   );

   bind_node #(.id_p(NODE0_ID), .data_bits_p(NODE0_BITS)) mon0 (
      .clk_dst_i(clk), .rst_n_i(rst_n), .data_i(node0_data), .exp_i(exp0),
      .err_cnt_o(mon0_err), .chg_cnt_o(mon0_chg));
   bind_node #(.id_p(NODE1_ID), .data_bits_p(NODE1_BITS)) mon1 (
      .clk_dst_i(clk), .rst_n_i(rst_n), .data_i(node1_data), .exp_i(exp1),
      .err_cnt_o(mon1_err), .chg_cnt_o(mon1_chg));
   bind_node #(.id_p(NODE2_ID), .data_bits_p(NODE2_BITS)) mon2 (
      .clk_dst_i(clk), .rst_n_i(rst_n), .data_i(node2_data), .exp_i(exp2),
      .err_cnt_o(mon2_err), .chg_cnt_o(mon2_chg));

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         err_cnt++;
         $display("** Error: %s expected %h got %h at %0t", name, expected, actual, $time);
      end
   endtask

   // sample ack at falling edges until it shows the wanted level
   task automatic wait_for_ack(input logic level);
      int cycles;
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (host_ack !== level && cycles < WAIT_LIMIT);
      if (host_ack !== level) begin
         $display("host_ack_o did not go %s within %0d cycles", level ? "high" : "low",
                  WAIT_LIMIT);
         timed_out = 1'b1;
      end
   endtask

   // one four-phase handshake, req held for hold extra cycles after ack
   task automatic do_write(input node_id_t id, input payload_t payload, input int hold);
      @(posedge clk);
      host_req     <= 1'b1;
      host_id      <= id;
      host_payload <= payload;
      wait_for_ack(1'b1);
      if (timed_out)
         return;
      repeat (hold) begin
         @(negedge clk);
         check_value("host_ack_o", host_ack, 1);
         check_value("uut.bus_0.valid", uut.bus_0.valid, 0);  // no new frame while parked
      end
      @(posedge clk);
      host_req <= 1'b0;
      wait_for_ack(1'b0);
   endtask

   initial begin
      int          fd, n, cycles, gap, lines;
      string       line;
      logic [31:0] f_id, f_pay, f_hold, f_gap, f_e0, f_e1, f_e2;
      host_req     = 1'b0;
      host_id      = '0;
      host_payload = '0;
      exp0  = NODE0_RST;
      exp1  = NODE1_RST;
      exp2  = NODE2_RST;
      lines = 0;
      foreach (exp_chg[k])
         exp_chg[k] = 0;
      cycles = 0;
      while (rst_n !== 1'b1 && cycles < WAIT_LIMIT) begin
         @(negedge clk);
         cycles++;
      end
      if (rst_n !== 1'b1) begin
         $display("reset was never released");
         timed_out = 1'b1;
      end
      check_value("host_ack_o", host_ack, 0);
      check_value("node0_data_o", node0_data, NODE0_RST);
      check_value("node1_data_o", node1_data, NODE1_RST);
      check_value("node2_data_o", node2_data, NODE2_RST);
      fd = $fopen("config_patterns.txt", "r");
      if (fd == 0) begin
         $display("could not open config_patterns.txt");
         err_cnt++;
      end else begin
         while (!$feof(fd) && !timed_out) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 0 && line[0] != "#")
               n = $sscanf(line, "%h %h %h %h %h %h %h", f_id, f_pay, f_hold, f_gap,
                           f_e0, f_e1, f_e2);
            else
               n = 0;
            if (n == 7) begin
               lines++;
               if (f_e0[NODE0_BITS-1:0] !== exp0) exp_chg[0]++;
               if (f_e1[NODE1_BITS-1:0] !== exp1) exp_chg[1]++;
               if (f_e2[NODE2_BITS-1:0] !== exp2) exp_chg[2]++;
               exp0 = f_e0[NODE0_BITS-1:0];
               exp1 = f_e1[NODE1_BITS-1:0];
               exp2 = f_e2[NODE2_BITS-1:0];
               do_write(f_id[ID_BITS-1:0], f_pay[PAYLOAD_BITS-1:0], f_hold);
               if (!timed_out) begin
                  repeat (NUM_NODES) @(negedge clk);  // last node settles NUM_NODES later
                  check_value("node0_data_o", node0_data, exp0);
                  check_value("node1_data_o", node1_data, exp1);
                  check_value("node2_data_o", node2_data, exp2);
               end
               gap = (f_gap > 5) ? $unsigned($random(seed)) % 6 : f_gap;
               repeat (gap) @(posedge clk);
            end
         end
         $fclose(fd);
         if (lines == 0) begin
            $display("config_patterns.txt holds no writes");
            err_cnt++;
         end
      end
      check_value("node0 change count", mon0_chg, exp_chg[0]);
      check_value("node1 change count", mon1_chg, exp_chg[1]);
      check_value("node2 change count", mon2_chg, exp_chg[2]);
      $display("errors: checks %0d, monitors %0d %0d %0d, timeout %0d", err_cnt,
               mon0_err, mon1_err, mon2_err, timed_out);
      if (err_cnt == 0 && mon0_err == 0 && mon1_err == 0 && mon2_err == 0 && !timed_out)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

// ==== config_patterns.txt ====
# id payload hold gap node0 node1 node2, all hex; hold is extra req cycles after ack
# gap is idle cycles before the next write, any value above 5 picks 0 to 5 at random
01 00A3 0 2 3 A0 1234
02 BEEF 0 0 3 EF 1234
10 CAFE 0 0 3 EF CAFE
20 5555 0 1 3 EF CAFE
FF 7896 0 F 6 96 7896
01 0009 3 0 9 96 7896
02 0096 0 0 9 96 7896
10 0001 0 F 9 96 0001
03 FFFF 4 F 9 96 0001
FF 0000 0 0 0 00 0000
01 FFFF 0 F F 00 0000
02 1234 0 F F 34 0000
10 ABCD 2 F F 34 ABCD
FF 1230 0 0 0 30 1230

// ==== src.f ====
config_pkg.sv
node_pkg.sv
config_serializer.sv
config_node.sv
config_net_top.sv
bind_node.sv
tb_clock_gen.sv
config_net_tb.sv

// ==== Bender.yml ====
package:
  name: config_net

sources:
  - config_pkg.sv
  - node_pkg.sv
  - config_serializer.sv
  - config_node.sv
  - config_net_top.sv
  - target: test
    files:
      - bind_node.sv
      - tb_clock_gen.sv
      - config_net_tb.sv
